// ==== verilog/cpu_pkg.sv ====
// Shared widths, encodings and bus structs for the 4-bit CPU; import inside each module body
package cpu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Widths and indices
	// ~~~~~~~~~~~~~~~~~~~~
	localparam int DATA_W    = 4;
	localparam int ADDR_W    = 11;
	localparam int INSTR_W   = 12;
	localparam int NUM_REGS  = 8;
	localparam int REG_IDX_W = 3;
	localparam int FLAG_REG  = 3;

	// Registers that hold the memory and jump address, low to high
	localparam int ADDR_REG_LO  = 4;
	localparam int ADDR_REG_MID = 5;
	localparam int ADDR_REG_HI  = 6;

	// Flag bit positions inside r3
	localparam int FLAG_C = 0;
	localparam int FLAG_B = 1;
	localparam int FLAG_Z = 2;
	localparam int FLAG_S = 3;

	// Option field values
	localparam logic [1:0] OPT_MOVI = 2'b01;
	localparam logic [1:0] OPT_OR   = 2'b10;
	localparam logic [1:0] OPT_NOT  = 2'b10;

	// ~~~~~~~~~~~~~~~~~~~~
	// Encodings
	// ~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		OPC_MOV     = 4'd0,
		OPC_STO     = 4'd1,
		OPC_LD      = 4'd2,
		OPC_ADD     = 4'd3,
		OPC_ADC     = 4'd4,
		OPC_SUB     = 4'd5,
		OPC_SBB     = 4'd6,
		OPC_AND_OR  = 4'd9,
		OPC_XOR_NOT = 4'd10,
		OPC_JMP     = 4'd11,
		OPC_JNZ     = 4'd12,
		OPC_NOP     = 4'd15
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOT
	} alu_op_e;

	typedef enum logic [2:0] {
		OP_NOP, OP_MOV, OP_MOVI, OP_LD, OP_STO, OP_ALU, OP_JMP, OP_JNZ
	} op_class_e;

	typedef enum logic [2:0] {
		S_FETCH0, S_FETCH1, S_FETCH2, S_EXEC, S_MEM
	} state_e;

	// ~~~~~~~~~~~~~~~~~~~~
	// Structs
	// ~~~~~~~~~~~~~~~~~~~~
	// First fetched nibble lands in the opcode
	typedef struct packed {
		opcode_e              opcode;
		logic [1:0]           option;
		logic [REG_IDX_W-1:0] arg1;
		logic [REG_IDX_W-1:0] arg2;
	} instr_t;

	typedef struct packed {
		op_class_e            op_class;
		alu_op_e              alu_op;
		logic [REG_IDX_W-1:0] dst;
		logic [REG_IDX_W-1:0] src;
	} ctrl_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              we;
		logic [DATA_W-1:0] wdata;
	} bus_out_t;

endpackage

// ==== verilog/instr_decode.sv ====
// Combinational decoder turning the held instruction into the sequencer's control struct
module instr_decode (
	input  cpu_pkg::instr_t instr_i,
	output cpu_pkg::ctrl_t  ctrl_o
);

	import cpu_pkg::*;

	always_comb begin
		// ALU form by default: dst = arg1, src = arg2
		ctrl_o.op_class = OP_NOP;
		ctrl_o.alu_op   = ALU_ADD;
		ctrl_o.dst      = instr_i.arg1;
		ctrl_o.src      = instr_i.arg2;

		case (instr_i.opcode)
			OPC_MOV: begin
				// Register copy goes r[arg1] -> r[arg2]
				ctrl_o.op_class = (instr_i.option == OPT_MOVI) ? OP_MOVI : OP_MOV;
				ctrl_o.dst      = instr_i.arg2;
				ctrl_o.src      = instr_i.arg1;
			end
			OPC_LD: begin
				ctrl_o.op_class = OP_LD;
				ctrl_o.dst      = instr_i.arg2;
			end
			OPC_STO: begin
				ctrl_o.op_class = OP_STO;
			end
			OPC_ADD: begin
				ctrl_o.op_class = OP_ALU;
				ctrl_o.alu_op   = ALU_ADD;
			end
			OPC_ADC: begin
				ctrl_o.op_class = OP_ALU;
				ctrl_o.alu_op   = ALU_ADC;
			end
			OPC_SUB: begin
				ctrl_o.op_class = OP_ALU;
				ctrl_o.alu_op   = ALU_SUB;
			end
			OPC_SBB: begin
				ctrl_o.op_class = OP_ALU;
				ctrl_o.alu_op   = ALU_SBB;
			end
			OPC_AND_OR: begin
				ctrl_o.op_class = OP_ALU;
				ctrl_o.alu_op   = (instr_i.option == OPT_OR) ? ALU_OR : ALU_AND;
			end
			OPC_XOR_NOT: begin
				ctrl_o.op_class = OP_ALU;
				if (instr_i.option == OPT_NOT) begin
					// NOT works in place on arg2
					ctrl_o.alu_op = ALU_NOT;
					ctrl_o.dst    = instr_i.arg2;
				end else begin
					ctrl_o.alu_op = ALU_XOR;
				end
			end
			OPC_JMP: begin
				ctrl_o.op_class = OP_JMP;
			end
			OPC_JNZ: begin
				ctrl_o.op_class = OP_JNZ;
			end
			default: begin
				ctrl_o.op_class = OP_NOP;
			end
		endcase
	end

endmodule

// ==== verilog/alu.sv ====
// Combinational 4-bit ALU; returns the result and the new flag nibble for r3
module alu (
	input  logic [cpu_pkg::DATA_W-1:0] a_i,
	input  logic [cpu_pkg::DATA_W-1:0] b_i,
	input  cpu_pkg::alu_op_e           op_i,
	input  logic [cpu_pkg::DATA_W-1:0] flags_i,
	output logic [cpu_pkg::DATA_W-1:0] result_o,
	output logic [cpu_pkg::DATA_W-1:0] flags_o
);

	import cpu_pkg::*;

	logic [DATA_W:0] wide;
	logic            is_add;
	logic            is_sub;
	logic [DATA_W:0] carry_in;
	logic [DATA_W:0] borrow_in;

	assign carry_in  = {{DATA_W{1'b0}}, flags_i[FLAG_C]};
	assign borrow_in = {{DATA_W{1'b0}}, flags_i[FLAG_B]};

	always_comb begin
		is_add = 1'b0;
		is_sub = 1'b0;
		case (op_i)
			ALU_ADD: begin
				wide   = {1'b0, a_i} + {1'b0, b_i};
				is_add = 1'b1;
			end
			ALU_ADC: begin
				wide   = {1'b0, a_i} + {1'b0, b_i} + carry_in;
				is_add = 1'b1;
			end
			// Bit 4 goes high when the difference wraps below zero
			ALU_SUB: begin
				wide   = {1'b0, a_i} - {1'b0, b_i};
				is_sub = 1'b1;
			end
			ALU_SBB: begin
				wide   = {1'b0, a_i} - {1'b0, b_i} - borrow_in;
				is_sub = 1'b1;
			end
			ALU_AND: wide = {1'b0, a_i & b_i};
			ALU_OR:  wide = {1'b0, a_i | b_i};
			ALU_XOR: wide = {1'b0, a_i ^ b_i};
			default: wide = {1'b0, ~b_i};
		endcase
	end

	assign result_o = wide[DATA_W-1:0];

	// Logic ops leave both carry and borrow clear
	always_comb begin
		flags_o         = '0;
		flags_o[FLAG_C] = is_add & wide[DATA_W];
		flags_o[FLAG_B] = is_sub & wide[DATA_W];
		flags_o[FLAG_Z] = (wide[DATA_W-1:0] == '0);
		flags_o[FLAG_S] = wide[DATA_W-1];
	end

endmodule

// ==== verilog/reg_file.sv ====
// Eight-entry nibble register file with result and flag write ports and the r6:r5:r4 address
module reg_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [cpu_pkg::REG_IDX_W-1:0] rd_a_idx_i,
	input  logic [cpu_pkg::REG_IDX_W-1:0] rd_b_idx_i,
	output logic [cpu_pkg::DATA_W-1:0]    rd_a_o,
	output logic [cpu_pkg::DATA_W-1:0]    rd_b_o,
	input  logic                          wr_en_i,
	input  logic [cpu_pkg::REG_IDX_W-1:0] wr_idx_i,
	input  logic [cpu_pkg::DATA_W-1:0]    wr_data_i,
	input  logic                          flag_we_i,
	input  logic [cpu_pkg::DATA_W-1:0]    flag_data_i,
	output logic [cpu_pkg::DATA_W-1:0]    flags_o,
	output logic [cpu_pkg::ADDR_W-1:0]    mem_addr_o
);

	import cpu_pkg::*;

	logic [DATA_W-1:0] regs_q [NUM_REGS];

	// ~~~~~~~~~~~~~~~~~~~~
	// Write ports
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else begin
			if (wr_en_i) begin
				regs_q[wr_idx_i] <= wr_data_i;
			end
			// Later assignment, so flags override a result aimed at r3
			if (flag_we_i) begin
				regs_q[FLAG_REG] <= flag_data_i;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Read ports
	// ~~~~~~~~~~~~~~~~~~~~
	assign rd_a_o  = regs_q[rd_a_idx_i];
	assign rd_b_o  = regs_q[rd_b_idx_i];
	assign flags_o = regs_q[FLAG_REG];

	// Only the low 3 bits of r6 reach the 11-bit bus
	assign mem_addr_o = {
		regs_q[ADDR_REG_HI][2:0],
		regs_q[ADDR_REG_MID],
		regs_q[ADDR_REG_LO]
	};

endmodule

// ==== verilog/cpu_seq.sv ====
// Fetch/execute sequencer: owns PC and instruction register, drives the bus and write-back
module cpu_seq (
	input  logic                          clk,
	input  logic                          rst_n,
	input  cpu_pkg::ctrl_t                ctrl_i,
	output cpu_pkg::instr_t               instr_o,
	input  logic [cpu_pkg::DATA_W-1:0]    bus_rdata_i,
	output logic [cpu_pkg::REG_IDX_W-1:0] rd_a_idx_o,
	output logic [cpu_pkg::REG_IDX_W-1:0] rd_b_idx_o,
	input  logic [cpu_pkg::DATA_W-1:0]    rd_b_i,
	input  logic [cpu_pkg::DATA_W-1:0]    flags_i,
	input  logic [cpu_pkg::ADDR_W-1:0]    mem_addr_i,
	input  logic [cpu_pkg::DATA_W-1:0]    alu_result_i,
	input  logic [cpu_pkg::DATA_W-1:0]    alu_flags_i,
	output logic                          wr_en_o,
	output logic [cpu_pkg::REG_IDX_W-1:0] wr_idx_o,
	output logic [cpu_pkg::DATA_W-1:0]    wr_data_o,
	output logic                          flag_we_o,
	output logic [cpu_pkg::DATA_W-1:0]    flag_data_o,
	output cpu_pkg::bus_out_t             bus_o
);

	import cpu_pkg::*;

	state_e             state_q;
	logic [ADDR_W-1:0]  pc_q;
	logic [INSTR_W-1:0] ir_q;
	logic               in_exec;
	logic               mem_access;
	logic               jump_taken;

	assign in_exec    = (state_q == S_EXEC);
	assign mem_access = (in_exec && (ctrl_i.op_class inside {OP_LD, OP_STO}))
	                    || (state_q == S_MEM);
	// JNZ branches while Z is clear
	assign jump_taken = in_exec && ((ctrl_i.op_class == OP_JMP)
	                    || ((ctrl_i.op_class == OP_JNZ) && !flags_i[FLAG_Z]));

	// ~~~~~~~~~~~~~~~~~~~~
	// State and PC
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst_n) begin
			state_q <= S_FETCH0;
			pc_q    <= '0;
		end else begin
			case (state_q)
				S_FETCH0: begin
					state_q <= S_FETCH1;
					pc_q    <= pc_q + ADDR_W'(1);
				end
				S_FETCH1: begin
					state_q <= S_FETCH2;
					pc_q    <= pc_q + ADDR_W'(1);
				end
				S_FETCH2: begin
					state_q <= S_EXEC;
					pc_q    <= pc_q + ADDR_W'(1);
				end
				S_EXEC: begin
					state_q <= (ctrl_i.op_class == OP_LD) ? S_MEM : S_FETCH0;
					// Immediate nibble sits right after the instruction
					if (ctrl_i.op_class == OP_MOVI) begin
						pc_q <= pc_q + ADDR_W'(1);
					end else if (jump_taken) begin
						pc_q <= mem_addr_i;
					end
				end
				default: state_q <= S_FETCH0;
			endcase
		end
	end

	// Instruction nibbles arrive high first
	always_ff @(posedge clk) begin
		case (state_q)
			S_FETCH0: ir_q[INSTR_W-1 -: DATA_W] <= bus_rdata_i;
			S_FETCH1: ir_q[INSTR_W-DATA_W-1 -: DATA_W] <= bus_rdata_i;
			S_FETCH2: ir_q[DATA_W-1:0] <= bus_rdata_i;
			default: ;
		endcase
	end

	assign instr_o    = instr_t'(ir_q);
	assign rd_a_idx_o = ctrl_i.dst;
	assign rd_b_idx_o = ctrl_i.src;

	// ~~~~~~~~~~~~~~~~~~~~
	// Write-back
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		wr_en_o   = (in_exec && (ctrl_i.op_class inside {OP_MOV, OP_MOVI, OP_ALU}))
		            || (state_q == S_MEM);
		wr_idx_o  = ctrl_i.dst;
		case (ctrl_i.op_class)
			OP_ALU:  wr_data_o = alu_result_i;
			OP_MOV:  wr_data_o = rd_b_i;
			default: wr_data_o = bus_rdata_i;
		endcase
	end

	assign flag_we_o   = in_exec && (ctrl_i.op_class == OP_ALU);
	assign flag_data_o = alu_flags_i;

	// Bus follows the PC except during data access
	always_comb begin
		bus_o       = '0;
		bus_o.addr  = mem_access ? mem_addr_i : pc_q;
		bus_o.we    = in_exec && (ctrl_i.op_class == OP_STO);
		bus_o.wdata = rd_b_i;
	end

endmodule

// ==== verilog/cpu_top.sv ====
// Top level of the 4-bit CPU, exposing the nibble memory bus to the system
module cpu_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [cpu_pkg::DATA_W-1:0] bus_rdata_i,
	output cpu_pkg::bus_out_t          bus_o
);

	import cpu_pkg::*;

	instr_t               instr;
	ctrl_t                ctrl;
	logic [REG_IDX_W-1:0] rd_a_idx;
	logic [REG_IDX_W-1:0] rd_b_idx;
	logic [DATA_W-1:0]    rd_a;
	logic [DATA_W-1:0]    rd_b;
	logic [DATA_W-1:0]    flags;
	logic [ADDR_W-1:0]    mem_addr;
	logic [DATA_W-1:0]    alu_result;
	logic [DATA_W-1:0]    alu_flags;
	logic                 wr_en;
	logic [REG_IDX_W-1:0] wr_idx;
	logic [DATA_W-1:0]    wr_data;
	logic                 flag_we;
	logic [DATA_W-1:0]    flag_data;

	cpu_seq u_seq (
		.clk(clk), .rst_n(rst_n),
		.ctrl_i(ctrl), .instr_o(instr), .bus_rdata_i(bus_rdata_i),
		.rd_a_idx_o(rd_a_idx), .rd_b_idx_o(rd_b_idx), .rd_b_i(rd_b),
		.flags_i(flags), .mem_addr_i(mem_addr),
		.alu_result_i(alu_result), .alu_flags_i(alu_flags),
		.wr_en_o(wr_en), .wr_idx_o(wr_idx), .wr_data_o(wr_data),
		.flag_we_o(flag_we), .flag_data_o(flag_data), .bus_o(bus_o)
	);

	instr_decode u_decode (.instr_i(instr), .ctrl_o(ctrl));

	alu u_alu (
		.a_i(rd_a), .b_i(rd_b), .op_i(ctrl.alu_op), .flags_i(flags),
		.result_o(alu_result), .flags_o(alu_flags)
	);

	reg_file u_regs (
		.clk(clk), .rst_n(rst_n),
		.rd_a_idx_i(rd_a_idx), .rd_b_idx_i(rd_b_idx), .rd_a_o(rd_a), .rd_b_o(rd_b),
		.wr_en_i(wr_en), .wr_idx_i(wr_idx), .wr_data_i(wr_data),
		.flag_we_i(flag_we), .flag_data_i(flag_data),
		.flags_o(flags), .mem_addr_o(mem_addr)
	);

endmodule

// ==== tb/tb_clkgen.sv ====
// Free-running testbench clock source; instantiate once in the testbench top
module tb_clkgen (
	output logic clk_o
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam time HALF_PERIOD = 4ns;

	initial begin
		clk_o = 1'b0;
	end

	// 8 ns period
	always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

// ==== tb/cpu_properties.sv ====
// Write strobe assertions for the sequencer that the testbench binds into cpu_seq
module cpu_properties (
	input logic               clk,
	input logic               rst_n,
	input cpu_pkg::state_e    state_i,
	input cpu_pkg::opcode_e   opcode_i,
	input logic               we_i
);

	timeunit 1ns;
	timeprecision 100ps;

	import cpu_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~
	// Strobe rules
	// ~~~~~~~~~~~~~~~~~~~~
	// Strobe only in the execute cycle of a fetched STO opcode
	a_we_only_sto: assert property (@(posedge clk) disable iff (rst_n)
		we_i |-> (state_i == S_EXEC && opcode_i == OPC_STO))
	else $error("write strobe high outside the STO execute cycle");

	// Single-cycle pulse
	a_we_single: assert property (@(posedge clk) disable iff (rst_n)
		we_i |=> !we_i)
	else $error("write strobe high for two cycles in a row");

	a_we_after_reset: assert property (@(posedge clk)
		rst_n |=> !we_i)
	else $error("write strobe high in the cycle after reset");

endmodule

// ==== tb/tb_cpu.sv ====
// Testbench top with the nibble memory model, program load from the pattern file and store checks
module tb_cpu;

	timeunit 1ns;
	timeprecision 100ps;

	import cpu_pkg::*;

	localparam int MEM_DEPTH   = 1 << ADDR_W;
	localparam int PAT_DEPTH   = 512;
	localparam int TAIL_CYCLES = 64;

	logic              clk;
	logic              rst_n;
	logic [DATA_W-1:0] bus_rdata;
	bus_out_t          bus;

	logic [DATA_W-1:0] mem [MEM_DEPTH];
	logic [15:0]       pat [PAT_DEPTH];

	int                prog_len;
	int                exp_cnt;
	int                store_cnt;
	int                errors;
	int                cycles;
	int                limit;
	bit                timed_out;

	logic              wr_pend;
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;

	tb_clkgen u_clkgen (.clk_o(clk));

	cpu_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.bus_rdata_i(bus_rdata),
		.bus_o(bus)
	);

	bind cpu_seq cpu_properties u_props (
		.clk(clk),
		.rst_n(rst_n),
		.state_i(state_q),
		.opcode_i(instr_o.opcode),
		.we_i(bus_o.we)
	);

	task automatic check_value(input string name, input logic [15:0] actual,
	                           input logic [15:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t %s actual=%h expected=%h", $time, name, actual, expected);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Memory model
	// ~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk) begin
		bus_rdata <= mem[bus.addr];
	end

	// Strobe sampled mid-cycle and store committed on the next rising edge
	always @(negedge clk) begin
		logic [15:0] rec;
		wr_pend = 1'b0;
		if (!rst_n && bus.we === 1'b1) begin
			wr_pend = 1'b1;
			wr_addr = bus.addr;
			wr_data = bus.wdata;
			if (store_cnt < exp_cnt) begin
				rec = pat[2 + prog_len + store_cnt];
				check_value("bus_o.addr", 16'(bus.addr), {4'h0, rec[15:4]});
				check_value("bus_o.wdata", 16'(bus.wdata), {12'h000, rec[3:0]});
			end else begin
				errors++;
				$display("Unexpected store of %h to address %h at %0t beyond the %0d expected",
				         bus.wdata, bus.addr, $time, exp_cnt);
			end
			store_cnt++;
		end
	end

	always @(posedge clk) begin
		if (wr_pend) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~
	initial begin
		rst_n     = 1'b1;
		bus_rdata = '0;
		wr_pend   = 1'b0;
		wr_addr   = '0;
		wr_data   = '0;
		errors    = 0;
		store_cnt = 0;
		cycles    = 0;
		timed_out = 1'b0;
		exp_cnt   = 0;
		prog_len  = 0;
		for (int i = 0; i < MEM_DEPTH; i++) begin
			mem[i] = '0;
		end
		for (int i = 0; i < PAT_DEPTH; i++) begin
			pat[i] = '0;
		end

		$readmemh("tb/cpu_patterns.hex", pat);
		prog_len = int'(pat[0]);
		exp_cnt  = int'(pat[1]);
		if (prog_len == 0 || exp_cnt == 0) begin
			errors++;
			$display("Pattern file holds no program or no expected stores");
		end
		for (int i = 0; i < prog_len; i++) begin
			mem[i] = pat[2 + i][DATA_W-1:0];
		end
		limit = 10 * prog_len + 200;

		repeat (16) @(negedge clk);
		rst_n = 1'b0;

		// Store count settles on the falling edge, so poll on the rising one
		while (store_cnt < exp_cnt && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end

		if (store_cnt < exp_cnt) begin
			timed_out = 1'b1;
			$display("Timeout after %0d cycles with %0d of %0d stores seen",
			         cycles, store_cnt, exp_cnt);
			for (int i = store_cnt; i < exp_cnt; i++) begin
				$display("Missing store of %h to address %h",
				         pat[2 + prog_len + i][3:0], pat[2 + prog_len + i][15:4]);
			end
		end else begin
			// Program parks in a self jump; any later store is stray
			repeat (TAIL_CYCLES) @(posedge clk);
		end

		$display("Errors: %0d, stores seen: %0d of %0d", errors, store_cnt, exp_cnt);
		if (errors == 0 && !timed_out) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== tb/cpu_patterns.hex ====
// Word 0 program length in nibbles, word 1 expected store count
// Then the program image one nibble per word, then stores as {addr[11:0], value}
00F3 0011
// Immediates and plain stores, address base 0x400
0 4 6 4   // MOVI r6,4
0 4 0 9   // MOVI r0,9
0 4 1 7   // MOVI r1,7
0 4 4 0   // MOVI r4,0
1 0 0     // STO r0
0 4 4 1   // MOVI r4,1
1 0 1     // STO r1
// Arithmetic with carry and borrow chaining
3 0 1     // ADD r0,r1
0 4 4 2
1 0 0     // STO r0
0 4 4 3
1 0 3     // STO r3
4 0 8     // ADC r1,r0
0 4 4 4
1 0 1     // STO r1
0 4 4 5
1 0 3     // STO r3
5 0 1     // SUB r0,r1
0 4 4 6
1 0 0     // STO r0
0 4 4 7
1 0 3     // STO r3
6 1 0     // SBB r2,r0
0 4 4 8
1 0 2     // STO r2
0 4 4 9
1 0 3     // STO r3
// Logic ops
9 1 1     // AND r2,r1
0 4 4 A
1 0 3     // STO r3
9 9 0     // OR r2,r0
0 4 4 B
1 0 2     // STO r2
0 4 7 5   // MOVI r7,5
A 3 8     // XOR r7,r0
0 4 4 C
1 0 7     // STO r7
A 8 7     // NOT r7
0 4 4 D
1 0 7     // STO r7
0 4 4 E
1 0 3     // STO r3
// Load of the data nibble at 0x0F2
0 4 6 0
0 4 5 F
0 4 4 2
2 0 2     // LD r2
0 1 0     // MOV r2 to r0
0 4 6 4
0 4 5 0
0 4 4 F
1 0 0     // STO r0
// Jumps
0 4 6 0
0 4 5 C
0 4 4 4
B 0 0     // JMP 0x0C4
1 0 0     // skipped
0 4 4 E
C 0 0     // JNZ 0x0CE, Z clear
1 0 0     // skipped
5 0 0     // SUB r0,r0 sets Z
0 4 6 4
0 4 5 1
0 4 4 0
C 0 0     // JNZ falls through
1 0 3     // STO r3
0 4 6 0
0 4 5 E
0 4 4 F
B 0 0     // JMP to itself
6         // data nibble
// Expected stores
4009 4017 4020 4035 4048 4058 4068 407A
4087 4092 40A4 40B8 40CD 40D2 40E0 40F6
4104

// ==== sources.f ====
verilog/cpu_pkg.sv
verilog/instr_decode.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/cpu_seq.sv
verilog/cpu_top.sv
tb/tb_clkgen.sv
tb/cpu_properties.sv
tb/tb_cpu.sv

// ==== Makefile ====
TOP := tb_cpu
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
